/* tb/doe_testdata.hex */
// Four 32-bit dwords per line, the most significant dword first
// Order: key, UDS, FE, IV A, IV B, expected UDS plaintext, expected FE plaintext
// Key, high half then low half
A7A7A7A7 A7A7A7A7 A7A7A7A7 A7A7A7A7
4D4D4D4D 4D4D4D4D 4D4D4D4D 4D4D4D4D
// Obfuscated UDS, blocks 0 to 2
01234567 89ABCDEF FEDCBA98 76543210
0F1E2D3C 4B5A6978 8796A5B4 C3D2E1F0
13579BDF 02468ACE 11223344 55667788
// Obfuscated FE, blocks 0 and 1
31415926 53589793 23846264 33832795
27182818 28459045 23536028 74713526
// IV A
00010203 04050607 08090A0B 0C0D0E0F
// IV B
F0E1D2C3 B4A59687 78695A4B 3C2D1E0F
// Expected UDS plaintext, offsets 0 to 11
89EECF20 05624353 7E1938D7 F295B4A4
C2D3A4F1 0E1F68B5 B5A4D386 79681FC2
78783C3C 7878B43E 85582FE3 D00D7AB4
// Expected FE plaintext, offsets 0 to 7
21D6E3A5 62D756E3 6C65294D 31EFD879
37742407 7738E4E1 6EF92F19 234637E3

/* all.f */
verilog/doe_pkg.sv
verilog/doe_regs.sv
verilog/doe_core_cbc.sv
verilog/doe_fsm.sv
verilog/kv_result_buffer.sv
verilog/doe_cbc.sv
tb/doe_cbc_assertions.sv
tb/doe_cbc_tb.sv

/* Bender.yml */
package:
  name: doe_cbc

sources:
  # RTL, package first
  - verilog/doe_pkg.sv
  - verilog/doe_regs.sv
  - verilog/doe_core_cbc.sv
  - verilog/doe_fsm.sv
  - verilog/kv_result_buffer.sv
  - verilog/doe_cbc.sv
  # Testbench
  - target: test
    files:
      - tb/doe_cbc_assertions.sv
      - tb/doe_cbc_tb.sv

/* tb/doe_cbc_tb.sv */
`timescale 1ns/1ns

module doe_cbc_tb;

  localparam int NUM_ROUNDS = 8;
  // Register reads and writes over the run, status polls included
  localparam int BUS_ACCESSES = 200;
  localparam int TOTAL_BLOCKS = doe_pkg::UDS_BLOCKS + doe_pkg::FE_BLOCKS;
  localparam int CYCLE_LIMIT  = 40 * (TOTAL_BLOCKS * (NUM_ROUNDS + 6) + BUS_ACCESSES);

  // ------------------------------
  // Data file layout, in dwords
  // ------------------------------
  localparam int KEY_BASE     = 0;
  localparam int UDS_BASE     = 8;
  localparam int FE_BASE      = 20;
  localparam int IV_A_BASE    = 28;
  localparam int IV_B_BASE    = 32;
  localparam int EXP_UDS_BASE = 36;
  localparam int EXP_FE_BASE  = 48;
  localparam int DATA_WORDS   = 56;

  logic                                       clk;
  logic                                       reset_n;
  logic                                       cs;
  logic                                       we;
  logic [doe_pkg::REG_ADDR_WIDTH-1:0]         address;
  logic [31:0]                                write_data;
  logic [31:0]                                read_data;
  logic [doe_pkg::KEY_DWORDS*32-1:0]          obf_key;
  logic [doe_pkg::UDS_DWORDS*32-1:0]          obf_uds;
  logic [doe_pkg::FE_DWORDS*32-1:0]           obf_fe;
  logic                                       notif_intr;
  logic                                       clear_obf_secrets;
  logic                                       kv_write_en;
  logic [doe_pkg::KV_ENTRY_WIDTH-1:0]         kv_write_entry;
  logic [doe_pkg::KV_OFFSET_WIDTH-1:0]        kv_write_offset;
  logic [31:0]                                kv_write_data;

  logic [31:0]                                testdata [0:DATA_WORDS-1];
  logic [doe_pkg::KV_ENTRY_WIDTH-1:0]         kv_entry_q[$];
  logic [doe_pkg::KV_OFFSET_WIDTH-1:0]        kv_offset_q[$];
  logic [31:0]                                kv_data_q[$];
  int                                         clear_count;
  int                                         cycle_count;

  doe_cbc #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) dut (
    .clk               (clk),
    .reset_n           (reset_n),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .read_data         (read_data),
    .obf_key           (obf_key),
    .obf_uds           (obf_uds),
    .obf_fe            (obf_fe),
    .notif_intr        (notif_intr),
    .clear_obf_secrets (clear_obf_secrets),
    .kv_write_en       (kv_write_en),
    .kv_write_entry    (kv_write_entry),
    .kv_write_offset   (kv_write_offset),
    .kv_write_data     (kv_write_data)
  );

  // Checker sees the sequencer state and core handshake inside the DUT
  bind doe_cbc doe_cbc_assertions u_assertions (
    .clk               (clk),
    .reset_n           (reset_n),
    .kv_write_en       (kv_write_en),
    .kv_write_offset   (kv_write_offset),
    .flow_done         (flow_done),
    .clear_obf_secrets (clear_obf_secrets),
    .core_next         (core_next),
    .core_busy         (u_core.busy),
    .fsm_state         (u_fsm.state)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Key-vault and clear monitor
  // ------------------------------
  // Mid-cycle sampling, all watched outputs come from registers
  always @(negedge clk) begin
    if (reset_n && kv_write_en) begin
      kv_entry_q.push_back(kv_write_entry);
      kv_offset_q.push_back(kv_write_offset);
      kv_data_q.push_back(kv_write_data);
    end
    if (reset_n && clear_obf_secrets) begin
      clear_count++;
    end
  end

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("[ERROR] %0t ns: %s", $time, msg));
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
    end
  endtask

  task automatic check_cmd(input string what, input doe_pkg::doe_cmd_e got,
                           input doe_pkg::doe_cmd_e exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    end
  endtask

  task automatic check_slot(input string what,
                            input logic [doe_pkg::KV_ENTRY_WIDTH-1:0] got_entry,
                            input logic [doe_pkg::KV_OFFSET_WIDTH-1:0] got_offset,
                            input logic [doe_pkg::KV_ENTRY_WIDTH-1:0] exp_entry,
                            input logic [doe_pkg::KV_OFFSET_WIDTH-1:0] exp_offset);
    if ((got_entry !== exp_entry) || (got_offset !== exp_offset)) begin
      report_mismatch($sformatf("%s: got entry %0d offset %0d, expected entry %0d offset %0d",
                                what, got_entry, got_offset, exp_entry, exp_offset));
    end
  endtask

  // ------------------------------
  // Register bus
  // ------------------------------
  task automatic reg_write(input logic [doe_pkg::REG_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  // read_data is registered, valid one cycle after the request
  task automatic reg_read(input logic [doe_pkg::REG_ADDR_WIDTH-1:0] addr,
                          output logic [31:0] data);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = addr;
    @(negedge clk);
    cs   = 1'b0;
    data = read_data;
  endtask

  // IV dword 0 at the lowest address, read back after the write
  task automatic load_iv(input int base);
    logic [doe_pkg::REG_ADDR_WIDTH-1:0] addr;
    logic [31:0]                        rd;
    for (int i = 0; i < 4; i++) begin
      addr = doe_pkg::ADDR_IV0 + 4 * i;
      reg_write(addr, testdata[base + i]);
      reg_read(addr, rd);
      check_word($sformatf("IV dword %0d", i), rd, testdata[base + i]);
    end
  endtask

  // Issue a command, then poll the valid bit until the flow ends
  task automatic run_command(input doe_pkg::doe_cmd_e cmd,
                             input logic [doe_pkg::KV_ENTRY_WIDTH-1:0] dest);
    logic [31:0] status;
    reg_write(doe_pkg::ADDR_CTRL, {27'b0, dest, cmd});
    status = '0;
    while (status[1] == 1'b0) begin
      reg_read(doe_pkg::ADDR_STATUS, status);
    end
  endtask

  // Compare collected writes with the file, then drop them
  task automatic check_kv_writes(input logic [doe_pkg::KV_ENTRY_WIDTH-1:0] entry,
                                 input int exp_base, input int count);
    check_word("kv write count", 32'(kv_data_q.size()), 32'(count));
    for (int i = 0; i < count; i++) begin
      check_slot($sformatf("kv write %0d slot", i), kv_entry_q[i], kv_offset_q[i],
                 entry, doe_pkg::KV_OFFSET_WIDTH'(i));
      check_word($sformatf("kv write %0d data", i), kv_data_q[i], testdata[exp_base + i]);
    end
    kv_entry_q.delete();
    kv_offset_q.delete();
    kv_data_q.delete();
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    cycle_count = 0;
    forever begin
      @(negedge clk);
      cycle_count++;
      if (dut.u_assertions.error_count != 0) begin
        abort_run("A bound assertion on the DUT failed");
      end else if (cycle_count >= CYCLE_LIMIT) begin
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    logic [31:0] rd;
    cs          = 1'b0;
    we          = 1'b0;
    address     = '0;
    write_data  = '0;
    reset_n     = 1'b0;
    obf_key     = '0;
    obf_uds     = '0;
    obf_fe      = '0;
    clear_count = 0;
    $readmemh("tb/doe_testdata.hex", testdata);
    if ($isunknown(testdata[DATA_WORDS-1])) begin
      abort_run("Data file tb/doe_testdata.hex is missing or too short");
    end
    // Secrets held static, dword 0 most significant
    for (int i = 0; i < doe_pkg::KEY_DWORDS; i++) begin
      obf_key[doe_pkg::KEY_DWORDS*32-1 - 32*i -: 32] = testdata[KEY_BASE + i];
    end
    for (int i = 0; i < doe_pkg::UDS_DWORDS; i++) begin
      obf_uds[doe_pkg::UDS_DWORDS*32-1 - 32*i -: 32] = testdata[UDS_BASE + i];
    end
    for (int i = 0; i < doe_pkg::FE_DWORDS; i++) begin
      obf_fe[doe_pkg::FE_DWORDS*32-1 - 32*i -: 32] = testdata[FE_BASE + i];
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset values
    reg_read(doe_pkg::ADDR_STATUS, rd);
    check_word("status after reset", rd, 32'h1);
    reg_read(doe_pkg::ADDR_CTRL, rd);
    check_cmd("control after reset", doe_pkg::doe_cmd_e'(rd[1:0]), doe_pkg::DOE_IDLE);
    check_word("notif_intr after reset", {31'b0, notif_intr}, 32'h0);
    check_word("kv writes after reset", 32'(kv_data_q.size()), 32'h0);

    // UDS to slot 5 with IV A, interrupt enabled
    reg_write(doe_pkg::ADDR_INTR_EN, 32'h1);
    load_iv(IV_A_BASE);
    run_command(doe_pkg::DOE_UDS, 3'd5);
    check_kv_writes(3'd5, EXP_UDS_BASE, doe_pkg::UDS_DWORDS);
    check_word("notif_intr after UDS", {31'b0, notif_intr}, 32'h1);
    reg_write(doe_pkg::ADDR_INTR_STS, 32'h1);
    check_word("notif_intr after clear", {31'b0, notif_intr}, 32'h0);

    // FE to slot 2 with IV B, interrupt masked
    reg_write(doe_pkg::ADDR_INTR_EN, 32'h0);
    load_iv(IV_B_BASE);
    run_command(doe_pkg::DOE_FE, 3'd2);
    check_kv_writes(3'd2, EXP_FE_BASE, doe_pkg::FE_DWORDS);
    reg_read(doe_pkg::ADDR_STATUS, rd);
    check_word("status after FE", rd, 32'h0F);
    reg_read(doe_pkg::ADDR_CTRL, rd);
    check_cmd("control after FE", doe_pkg::doe_cmd_e'(rd[1:0]), doe_pkg::DOE_IDLE);
    check_word("dest after FE", {29'b0, rd[4:2]}, 32'h2);

    // Pending interrupt shows only once enabled
    check_word("notif_intr masked", {31'b0, notif_intr}, 32'h0);
    reg_read(doe_pkg::ADDR_INTR_STS, rd);
    check_word("interrupt status after FE", rd, 32'h1);
    reg_write(doe_pkg::ADDR_INTR_EN, 32'h1);
    check_word("notif_intr unmasked", {31'b0, notif_intr}, 32'h1);
    reg_write(doe_pkg::ADDR_INTR_STS, 32'h1);
    check_word("notif_intr after second clear", {31'b0, notif_intr}, 32'h0);

    // Locked UDS, no writes
    run_command(doe_pkg::DOE_UDS, 3'd5);
    check_kv_writes(3'd5, EXP_UDS_BASE, 0);
    reg_read(doe_pkg::ADDR_STATUS, rd);
    check_word("status after locked UDS", rd, 32'h0F);

    // Clear of the obfuscated secrets
    run_command(doe_pkg::DOE_CLEAR, 3'd0);
    check_word("clear pulse count", 32'(clear_count), 32'h1);
    check_kv_writes(3'd0, 0, 0);
    reg_read(doe_pkg::ADDR_STATUS, rd);
    check_word("status after clear", rd, 32'h1F);

    if (dut.u_assertions.error_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run("Bound assertions on the DUT reported failures");
    end
  end

endmodule

/* tb/doe_cbc_assertions.sv */
`timescale 1ns/1ns

module doe_cbc_assertions (
  input logic                                 clk,
  input logic                                 reset_n,
  input logic                                 kv_write_en,
  input logic [doe_pkg::KV_OFFSET_WIDTH-1:0]  kv_write_offset,
  input logic                                 flow_done,
  input logic                                 clear_obf_secrets,
  input logic                                 core_next,
  input logic                                 core_busy,
  input doe_pkg::doe_state_e                  fsm_state
);

  // Tally of failed properties, polled by the testbench
  int error_count = 0;

  // ------------------------------
  // Reset behavior
  // ------------------------------
  // Sequencer parked in IDLE, no strobes
  reset_quiet: assert property (@(posedge clk)
    !reset_n |-> !kv_write_en && !flow_done && !clear_obf_secrets &&
                 (fsm_state == doe_pkg::IDLE))
    else begin
      $error("kv_write_en, flow_done or clear_obf_secrets active during reset");
      error_count++;
    end

  // ------------------------------
  // Handshakes and ranges
  // ------------------------------
  // Core takes a block only when its round loop is idle
  next_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
    core_next |-> !core_busy)
    else begin
      $error("next issued while the core was busy");
      error_count++;
    end

  // Largest secret is the UDS
  offset_range: assert property (@(posedge clk) disable iff (!reset_n)
    kv_write_en |-> (kv_write_offset < doe_pkg::UDS_DWORDS))
    else begin
      $error("key-vault offset out of range");
      error_count++;
    end

  done_single: assert property (@(posedge clk) disable iff (!reset_n)
    flow_done |=> !flow_done)
    else begin
      $error("flow_done longer than one cycle");
      error_count++;
    end

endmodule

/* verilog/doe_cbc.sv */
`timescale 1ns/1ns

module doe_cbc #(
  parameter int NUM_ROUNDS = 8
) (
  input  logic                                 clk,
  input  logic                                 reset_n,
  // Register bus
  input  logic                                 cs,
  input  logic                                 we,
  input  logic [doe_pkg::REG_ADDR_WIDTH-1:0]   address,
  input  logic [31:0]                          write_data,
  output logic [31:0]                          read_data,
  // Static secrets
  input  logic [doe_pkg::KEY_DWORDS*32-1:0]    obf_key,
  input  logic [doe_pkg::UDS_DWORDS*32-1:0]    obf_uds,
  input  logic [doe_pkg::FE_DWORDS*32-1:0]     obf_fe,
  output logic                                 notif_intr,
  output logic                                 clear_obf_secrets,
  // Key-vault write port
  output logic                                 kv_write_en,
  output logic [doe_pkg::KV_ENTRY_WIDTH-1:0]   kv_write_entry,
  output logic [doe_pkg::KV_OFFSET_WIDTH-1:0]  kv_write_offset,
  output logic [31:0]                          kv_write_data
);

  doe_pkg::doe_cmd_e cmd;

  logic [doe_pkg::KV_ENTRY_WIDTH-1:0] dest;
  logic [doe_pkg::KV_ENTRY_WIDTH-1:0] kv_entry;
  logic [127:0] iv;
  logic [127:0] core_block;
  logic [127:0] core_result;
  logic [1:0]   block_index;
  logic         iv_updated;
  logic         flow_done;
  logic         flow_busy;
  logic         uds_locked;
  logic         fe_locked;
  logic         core_init;
  logic         core_next;
  logic         core_ready;
  logic         core_valid;
  logic         push_done;

  // ------------------------------
  // Firmware registers
  // ------------------------------
  doe_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .cmd           (cmd),
    .dest          (dest),
    .iv            (iv),
    .iv_updated    (iv_updated),
    .flow_done     (flow_done),
    .flow_busy     (flow_busy),
    .cleared_pulse (clear_obf_secrets),
    .uds_locked    (uds_locked),
    .fe_locked     (fe_locked),
    .core_ready    (core_ready),
    .notif_intr    (notif_intr)
  );

  // ------------------------------
  // Flow sequencer
  // ------------------------------
  doe_fsm u_fsm (
    .clk               (clk),
    .reset_n           (reset_n),
    .cmd               (cmd),
    .dest              (dest),
    .obf_uds           (obf_uds),
    .obf_fe            (obf_fe),
    .core_ready        (core_ready),
    .core_valid        (core_valid),
    .push_done         (push_done),
    .init              (core_init),
    .next              (core_next),
    .block             (core_block),
    .kv_entry          (kv_entry),
    .block_index       (block_index),
    .flow_done         (flow_done),
    .flow_busy         (flow_busy),
    .clear_obf_secrets (clear_obf_secrets),
    .uds_locked        (uds_locked),
    .fe_locked         (fe_locked)
  );

  // Decrypt core, always 256-bit key
  doe_core_cbc #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) u_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .init         (core_init),
    .next         (core_next),
    .key          (obf_key),
    .iv           (iv),
    .iv_updated   (iv_updated),
    .block        (core_block),
    .ready        (core_ready),
    .result       (core_result),
    .result_valid (core_valid)
  );

  // Plaintext out to the key vault
  kv_result_buffer u_kv_buf (
    .clk             (clk),
    .reset_n         (reset_n),
    .result_valid    (core_valid),
    .result          (core_result),
    .kv_entry        (kv_entry),
    .block_index     (block_index),
    .kv_write_en     (kv_write_en),
    .kv_write_entry  (kv_write_entry),
    .kv_write_offset (kv_write_offset),
    .kv_write_data   (kv_write_data),
    .push_done       (push_done)
  );

endmodule

/* verilog/kv_result_buffer.sv */
`timescale 1ns/1ns

module kv_result_buffer (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 result_valid,
  input  logic [127:0]                         result,
  input  logic [doe_pkg::KV_ENTRY_WIDTH-1:0]   kv_entry,
  input  logic [1:0]                           block_index,
  output logic                                 kv_write_en,
  output logic [doe_pkg::KV_ENTRY_WIDTH-1:0]   kv_write_entry,
  output logic [doe_pkg::KV_OFFSET_WIDTH-1:0]  kv_write_offset,
  output logic [31:0]                          kv_write_data,
  output logic                                 push_done
);

  logic [127:0] data_reg;
  logic [1:0]   dw_cnt;
  logic [1:0]   blk_reg;
  logic         busy;

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy   <= 1'b0;
      dw_cnt <= '0;
    end else if (result_valid) begin
      busy   <= 1'b1;
      dw_cnt <= '0;
    end else if (busy) begin
      dw_cnt <= dw_cnt + 2'd1;
      // Fourth dword ends the burst
      if (dw_cnt == 2'd3) begin
        busy <= 1'b0;
      end
    end
  end

  // Block payload, shifted up a dword per write
  always_ff @(posedge clk) begin
    if (result_valid) begin
      data_reg       <= result;
      blk_reg        <= block_index;
      kv_write_entry <= kv_entry;
    end else if (busy) begin
      data_reg <= {data_reg[95:0], 32'b0};
    end
  end

  // ------------------------------
  // Key-vault port
  // ------------------------------
  assign kv_write_en     = busy;
  assign kv_write_data   = data_reg[127:96];
  // Offset base is 4 x block index
  assign kv_write_offset = {blk_reg, dw_cnt};
  assign push_done       = busy && (dw_cnt == 2'd3);

endmodule

/* verilog/doe_fsm.sv */
`timescale 1ns/1ns

module doe_fsm (
  input  logic                                clk,
  input  logic                                reset_n,
  input  doe_pkg::doe_cmd_e                   cmd,
  input  logic [doe_pkg::KV_ENTRY_WIDTH-1:0]  dest,
  input  logic [doe_pkg::UDS_DWORDS*32-1:0]   obf_uds,
  input  logic [doe_pkg::FE_DWORDS*32-1:0]    obf_fe,
  input  logic                                core_ready,
  input  logic                                core_valid,
  input  logic                                push_done,
  output logic                                init,
  output logic                                next,
  output logic [127:0]                        block,
  output logic [doe_pkg::KV_ENTRY_WIDTH-1:0]  kv_entry,
  output logic [1:0]                          block_index,
  output logic                                flow_done,
  output logic                                flow_busy,
  output logic                                clear_obf_secrets,
  output logic                                uds_locked,
  output logic                                fe_locked
);

  doe_pkg::doe_state_e state;
  doe_pkg::doe_state_e state_next;

  logic [1:0] blk_cnt;
  logic [1:0] last_blk;
  logic       is_uds;
  logic       is_flow;
  logic       flow_locked;

  // ------------------------------
  // Source selection
  // ------------------------------
  assign is_uds      = (cmd == doe_pkg::DOE_UDS);
  assign is_flow     = (cmd == doe_pkg::DOE_UDS) || (cmd == doe_pkg::DOE_FE);
  assign flow_locked = is_uds ? uds_locked : fe_locked;
  assign last_blk    = is_uds ? 2'(doe_pkg::UDS_BLOCKS - 1) : 2'(doe_pkg::FE_BLOCKS - 1);

  // Most significant block first, stable while the core runs
  always_comb begin
    if (is_uds) begin
      block = obf_uds[383 - 128*blk_cnt -: 128];
    end else begin
      block = obf_fe[255 - 128*blk_cnt[0] -: 128];
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      doe_pkg::IDLE: begin
        // Locked flow goes straight to DONE, no writes
        if (is_flow) begin
          state_next = flow_locked ? doe_pkg::DONE : doe_pkg::LOAD;
        end else if (cmd == doe_pkg::DOE_CLEAR) begin
          state_next = doe_pkg::DONE;
        end
      end
      doe_pkg::LOAD: state_next = doe_pkg::RUN;
      doe_pkg::RUN: begin
        if (core_ready) begin
          state_next = doe_pkg::WAIT;
        end
      end
      doe_pkg::WAIT: begin
        if (core_valid) begin
          state_next = doe_pkg::PUSH;
        end
      end
      doe_pkg::PUSH: begin
        if (push_done) begin
          state_next = (blk_cnt == last_blk) ? doe_pkg::DONE : doe_pkg::RUN;
        end
      end
      doe_pkg::DONE: state_next = doe_pkg::IDLE;
      default:       state_next = doe_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= doe_pkg::IDLE;
      blk_cnt    <= '0;
      kv_entry   <= '0;
      uds_locked <= 1'b0;
      fe_locked  <= 1'b0;
    end else begin
      state <= state_next;
      // Destination held for the whole flow
      if (state == doe_pkg::IDLE) begin
        blk_cnt  <= '0;
        kv_entry <= dest;
      end
      if ((state == doe_pkg::PUSH) && push_done) begin
        blk_cnt <= blk_cnt + 2'd1;
      end
      // Once per power cycle
      if ((state == doe_pkg::DONE) && (cmd == doe_pkg::DOE_UDS)) begin
        uds_locked <= 1'b1;
      end
      if ((state == doe_pkg::DONE) && (cmd == doe_pkg::DOE_FE)) begin
        fe_locked <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  // Key load once per flow
  assign init        = (state == doe_pkg::LOAD);
  // Leaves RUN on the same cycle, so one pulse
  assign next        = (state == doe_pkg::RUN) && core_ready;
  assign block_index = blk_cnt;
  assign flow_busy   = (state != doe_pkg::IDLE);
  assign flow_done   = (state == doe_pkg::DONE);
  assign clear_obf_secrets = (state == doe_pkg::DONE) && (cmd == doe_pkg::DOE_CLEAR);

endmodule

/* verilog/doe_core_cbc.sv */
`timescale 1ns/1ns

module doe_core_cbc #(
  parameter int NUM_ROUNDS = 8
) (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         init,
  input  logic         next,
  input  logic [255:0] key,
  input  logic [127:0] iv,
  input  logic         iv_updated,
  input  logic [127:0] block,
  output logic         ready,
  output logic [127:0] result,
  output logic         result_valid
);

  logic [255:0] key_reg;
  logic [127:0] state_reg;
  logic [127:0] chain_reg;
  logic [3:0]   round_ctr;
  logic         busy;
  logic         finish;

  // ------------------------------
  // Round function
  // ------------------------------
  // Even rounds use key high half, odd the low half, rotated left 8 per round
  function automatic logic [127:0] round_key(input logic [255:0] k, input logic [3:0] idx);
    logic [127:0] half;
    int unsigned  sh;
    half = idx[0] ? k[127:0] : k[255:128];
    sh   = 8 * idx;
    if (sh == 0) begin
      return half;
    end
    return (half << sh) | (half >> (128 - sh));
  endfunction

  // Add round key, then rotate right by 7
  function automatic logic [127:0] dec_round(input logic [127:0] s, input logic [127:0] rk);
    logic [127:0] x;
    x = s ^ rk;
    return {x[6:0], x[127:7]};
  endfunction

  // All rounds done, chaining cycle
  assign finish = busy && (round_ctr == 4'(NUM_ROUNDS));

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy         <= 1'b0;
      // Idle core takes work straight away
      ready        <= 1'b1;
      result_valid <= 1'b0;
      round_ctr    <= '0;
    end else begin
      result_valid <= 1'b0;
      if (init) begin
        ready <= 1'b1;
      end
      if (next) begin
        busy      <= 1'b1;
        ready     <= 1'b0;
        round_ctr <= '0;
      end else if (finish) begin
        busy         <= 1'b0;
        ready        <= 1'b1;
        result_valid <= 1'b1;
      end else if (busy) begin
        round_ctr <= round_ctr + 4'd1;
      end
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (init) begin
      key_reg <= key;
    end
    // Rounds applied in index order 0 .. NUM_ROUNDS-1
    if (next) begin
      state_reg <= block;
    end else if (busy && !finish) begin
      state_reg <= dec_round(state_reg, round_key(key_reg, round_ctr));
    end
    // CBC: plaintext = D(C) ^ previous C, then C becomes the chain
    if (finish) begin
      result    <= state_reg ^ chain_reg;
      chain_reg <= block;
    end else if (iv_updated) begin
      chain_reg <= iv;
    end
  end

endmodule

/* verilog/doe_regs.sv */
`timescale 1ns/1ns

module doe_regs (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cs,
  input  logic                                we,
  input  logic [doe_pkg::REG_ADDR_WIDTH-1:0]  address,
  input  logic [31:0]                         write_data,
  output logic [31:0]                         read_data,
  output doe_pkg::doe_cmd_e                   cmd,
  output logic [doe_pkg::KV_ENTRY_WIDTH-1:0]  dest,
  output logic [127:0]                        iv,
  output logic                                iv_updated,
  input  logic                                flow_done,
  input  logic                                flow_busy,
  input  logic                                cleared_pulse,
  input  logic                                uds_locked,
  input  logic                                fe_locked,
  input  logic                                core_ready,
  output logic                                notif_intr
);

  logic        wr;
  logic        ctrl_wr;
  logic        iv_hit;
  logic        iv_wr;
  logic        valid;
  logic        cleared;
  logic        intr_en;
  logic        intr_sts;
  logic [31:0] rd_mux;

  // ------------------------------
  // Write decode
  // ------------------------------
  assign wr = cs && we;
  // Commands are dropped while a flow runs
  assign ctrl_wr = wr && (address == doe_pkg::ADDR_CTRL) && !flow_busy;
  // IV dwords fill the upper half of the map
  assign iv_hit = (address[4] == doe_pkg::ADDR_IV0[4]);
  assign iv_wr  = wr && iv_hit;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cmd        <= doe_pkg::DOE_IDLE;
      dest       <= '0;
      valid      <= 1'b0;
      cleared    <= 1'b0;
      intr_en    <= 1'b0;
      intr_sts   <= 1'b0;
      iv_updated <= 1'b0;
      read_data  <= '0;
    end else begin
      // Core reloads its chain value on this
      iv_updated <= iv_wr;
      // Flow end retires the command
      if (flow_done) begin
        cmd   <= doe_pkg::DOE_IDLE;
        valid <= 1'b1;
      end else if (ctrl_wr) begin
        cmd   <= doe_pkg::doe_cmd_e'(write_data[1:0]);
        dest  <= write_data[4:2];
        valid <= 1'b0;
      end
      // Sticky until reset
      if (cleared_pulse) begin
        cleared <= 1'b1;
      end
      if (wr && (address == doe_pkg::ADDR_INTR_EN)) begin
        intr_en <= write_data[0];
      end
      // Set wins over W1C
      if (flow_done) begin
        intr_sts <= 1'b1;
      end else if (wr && (address == doe_pkg::ADDR_INTR_STS) && write_data[0]) begin
        intr_sts <= 1'b0;
      end
      if (cs && !we) begin
        read_data <= rd_mux;
      end
    end
  end

  // IV payload
  always_ff @(posedge clk) begin
    if (iv_wr) begin
      iv[127 - 32*address[3:2] -: 32] <= write_data;
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    rd_mux = '0;
    case (address)
      doe_pkg::ADDR_CTRL:     rd_mux = {27'b0, dest, cmd};
      doe_pkg::ADDR_STATUS:   rd_mux = {27'b0, cleared, fe_locked, uds_locked, valid,
                                        core_ready & ~flow_busy};
      doe_pkg::ADDR_INTR_EN:  rd_mux[0] = intr_en;
      doe_pkg::ADDR_INTR_STS: rd_mux[0] = intr_sts;
      default: begin
        if (iv_hit) begin
          rd_mux = iv[127 - 32*address[3:2] -: 32];
        end
      end
    endcase
  end

  // Level interrupt, masked
  assign notif_intr = intr_sts & intr_en;

endmodule

/* verilog/doe_pkg.sv */
package doe_pkg;

  // ------------------------------
  // Secret and block geometry
  // ------------------------------
  // Sizes in 32-bit dwords
  localparam int KEY_DWORDS   = 8;
  localparam int UDS_DWORDS   = 12;
  localparam int FE_DWORDS    = 8;
  localparam int BLOCK_DWORDS = 4;

  // 128-bit blocks per secret
  localparam int UDS_BLOCKS = UDS_DWORDS / BLOCK_DWORDS;
  localparam int FE_BLOCKS  = FE_DWORDS / BLOCK_DWORDS;

  // Key-vault write port
  localparam int KV_ENTRY_WIDTH  = 3;
  localparam int KV_OFFSET_WIDTH = 4;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam int REG_ADDR_WIDTH = 5;

  // Control: cmd in 1:0, dest in 4:2
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL     = 5'h00;
  // Status: ready, valid, uds_done, fe_done, cleared
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_STATUS   = 5'h04;
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_INTR_EN  = 5'h08;
  // Write 1 to clear
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_INTR_STS = 5'h0C;
  // Four IV dwords, dword 0 most significant
  localparam logic [REG_ADDR_WIDTH-1:0] ADDR_IV0      = 5'h10;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [1:0] {
    DOE_IDLE  = 2'd0,
    DOE_UDS   = 2'd1,
    DOE_FE    = 2'd2,
    DOE_CLEAR = 2'd3
  } doe_cmd_e;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE = 3'd0,
    LOAD = 3'd1,
    RUN  = 3'd2,
    WAIT = 3'd3,
    PUSH = 3'd4,
    DONE = 3'd5
  } doe_state_e;

endpackage
